/* tb.f */
+incdir+src
+incdir+verification
src/fp_pkg.sv
src/fp_stage_if.sv
src/fp_special_case.sv
src/fp_align.sv
src/fp_add_norm.sv
src/fp_addsub_top.sv
verification/tb_fp_addsub.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_fp_addsub
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := *** PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

# the log decides pass or fail, not the simulator exit code
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF -- '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/fp_ref_model.svh */
`ifndef FP_REF_MODEL_SVH
`define FP_REF_MODEL_SVH
`include "fp_macros.svh"
`default_nettype none

// expected {overflow, underflow, result} of a + b or a - b
// exact sum on wide integers, then truncated toward zero
function automatic logic [33:0] fp_expected(input logic [31:0] a, input logic [31:0] b,
                                            input logic sub);
    logic         sa;
    logic         sb;
    logic         sr;
    logic [7:0]   ea;
    logic [7:0]   eb;
    logic [299:0] ma;
    logic [299:0] mb;
    logic [299:0] m;
    logic [299:0] top;
    int           p;
    int           e;
    sa = a[31];
    sb = b[31] ^ sub;
    ea = a[30:23];
    eb = b[30:23];
    if ((ea == 8'hFF && a[22:0] != 0) || (eb == 8'hFF && b[22:0] != 0))
        return {2'b00, `FP_QNAN};
    if (ea == 8'hFF && eb == 8'hFF)
        return (sa != sb) ? {2'b00, `FP_QNAN} : {2'b00, sa, 8'hFF, 23'd0};
    if (ea == 8'hFF)
        return {2'b00, sa, 8'hFF, 23'd0};
    if (eb == 8'hFF)
        return {2'b00, sb, 8'hFF, 23'd0};
    if (a[30:0] == 0 && b[30:0] == 0)
        return {2'b00, sa & sb, 31'd0};
    if (a[30:0] == 0)
        return {2'b00, sb, b[30:0]};
    if (b[30:0] == 0)
        return {2'b00, sa, a[30:0]};
    // magnitudes as integers in units of 2^-149
    ma = 300'({ea != 8'd0, a[22:0]}) << ((ea == 8'd0) ? 0 : int'(ea) - 1);
    mb = 300'({eb != 8'd0, b[22:0]}) << ((eb == 8'd0) ? 0 : int'(eb) - 1);
    if (sa == sb) begin
        m  = ma + mb;
        sr = sa;
    end else if (ma >= mb) begin
        m  = ma - mb;
        sr = sa;
    end else begin
        m  = mb - ma;
        sr = sb;
    end
    if (m == 0)
        return 34'd0;
    p = 0;
    for (int i = 0; i < 300; i++) begin
        if (m[i])
            p = i;
    end
    // below 2^-126 the value is a subnormal and fits in the fraction
    if (p < 23)
        return {2'b01, sr, 8'h00, m[22:0]};
    e = p - 22;
    if (e > `FP_EXP_MAX)
        return {2'b10, sr, 8'hFF, 23'd0};
    top = m >> (p - 23);
    return {2'b00, sr, e[7:0], top[22:0]};
endfunction

`default_nettype wire
`endif

/* verification/tb_fp_addsub.sv */
`timescale 1ns/100ps
`include "fp_macros.svh"
`include "fp_ref_model.svh"
`default_nettype none

module tb_fp_addsub
    import fp_pkg::*;
();

    typedef struct packed {
        logic [31:0] a;
        logic [31:0] b;
        logic        ovf;
        logic        unf;
        logic [31:0] res;
    } expect_t;

    localparam int NUM_VECTORS    = 400;
    localparam int TIMEOUT_CYCLES = 1000;
    localparam logic [31:0] CORNERS [16] = '{
        32'h00000000, 32'h80000000, 32'h3F800000, 32'hBF800000,
        32'h7F800000, 32'hFF800000, 32'h7FC00000, 32'hFFFFFFFF,
        32'h7F7FFFFF, 32'hFF7FFFFF, 32'h00800000, 32'h80800000,
        32'h00000001, 32'h807FFFFF, 32'h40490FDB, 32'h34000000
    };

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic [31:0] operand_a;
    logic [31:0] operand_b;
    fp_op_t      operation;
    logic        out_valid;
    logic [31:0] result;
    logic        overflow;
    logic        underflow;

    expect_t     exp_q[$];
    expect_t     exp_cur;
    logic        chk;
    logic [1:0]  valid_pipe;
    logic [31:0] rng;
    logic        timed_out;
    int          errors;
    int          checked;
    int          mark_err;
    int          mark_cnt;

    fp_addsub_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .operation (operation),
        .out_valid (out_valid),
        .result    (result),
        .overflow  (overflow),
        .underflow (underflow)
    );

    always #10 clk = ~clk;

    // in_valid as seen two edges ago
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_pipe <= 2'b00;
        end else begin
            valid_pipe <= {valid_pipe[0], in_valid};
        end
    end

    // outputs are stable mid-cycle, pair them with the oldest expectation
    always @(negedge clk) begin
        chk = 1'b0;
        if (rst_n && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("out_valid rose with no input pending");
                errors++;
            end else begin
                exp_cur = exp_q.pop_front();
                chk     = 1'b1;
                checked++;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) chk |-> result == exp_cur.res)
        else begin
            $display("** Error: result = %h, expected %h (a %h, b %h)",
                     $sampled(result), exp_cur.res, exp_cur.a, exp_cur.b);
            errors++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) chk |-> overflow == exp_cur.ovf)
        else begin
            $display("** Error: overflow = %h, expected %h (a %h, b %h)",
                     $sampled(overflow), exp_cur.ovf, exp_cur.a, exp_cur.b);
            errors++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) chk |-> underflow == exp_cur.unf)
        else begin
            $display("** Error: underflow = %h, expected %h (a %h, b %h)",
                     $sampled(underflow), exp_cur.unf, exp_cur.a, exp_cur.b);
            errors++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) out_valid == valid_pipe[1])
        else begin
            $display("** Error: out_valid = %h, expected %h",
                     $sampled(out_valid), $sampled(valid_pipe[1]));
            errors++;
        end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        rng = xorshift(rng);
        r   = rng;
    endtask

    task automatic random_word(output logic [31:0] w);
        logic [31:0] sel;
        logic [31:0] r;
        next_rand(sel);
        next_rand(r);
        case (sel[1:0])
            2'd0:    w = CORNERS[sel[5:2]];
            2'd1:    w = {r[31], 8'h00, r[22:0]};
            default: w = r;
        endcase
    endtask

    task automatic send(input logic [31:0] a, input logic [31:0] b, input fp_op_t op);
        @(negedge clk);
        in_valid  = 1'b1;
        operand_a = a;
        operand_b = b;
        operation = op;
        exp_q.push_back(expect_t'({a, b, fp_expected(a, b, op == op_sub)}));
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic close_test(input string name);
        int waited;
        idle_cycle();
        waited = 0;
        while (exp_q.size() != 0 && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout in %s: %0d results never appeared", name, exp_q.size());
            timed_out = 1'b1;
            exp_q.delete();
        end
        // let the checks on the last result fire
        repeat (2) @(negedge clk);
        $display("test %-10s %0d results, %0d errors", name, checked - mark_cnt,
                 errors - mark_err);
        mark_cnt = checked;
        mark_err = errors;
    endtask

    task automatic normal_operands();
        logic [31:0] a;
        logic [31:0] b;
        send(32'h3F800000, 32'h40000000, op_add);
        send(32'h3FC00000, 32'h3FC00000, op_add);
        send(32'h40400000, 32'h403FFFFF, op_sub);
        send(32'hC0A00000, 32'h40400000, op_add);
        send(32'h3F800001, 32'h3F800000, op_sub);
        send(32'h4B7FFFFF, 32'h3F800000, op_add);
        send(32'h4B800000, 32'h3F800000, op_add);
        repeat (40) begin
            next_rand(a);
            next_rand(b);
            // exponents within a few steps so the significands overlap
            send({a[31], 8'd124 + {5'd0, a[25:23]}, a[22:0]},
                 {b[31], 8'd124 + {5'd0, b[25:23]}, b[22:0]},
                 a[30] ? op_sub : op_add);
        end
    endtask

    task automatic special_operands();
        send(32'h7FC00000, 32'h3F800000, op_add);
        send(32'h3F800000, 32'hFF800001, op_sub);
        send(32'h7F800000, 32'h7F800000, op_sub);
        send(32'hFF800000, 32'hFF800000, op_sub);
        send(32'hFF800000, 32'hFF800000, op_add);
        send(32'h7F800000, 32'h40A00000, op_add);
        send(32'h40A00000, 32'h7F800000, op_sub);
        send(32'h00000000, 32'h00000000, op_add);
        send(32'h80000000, 32'h80000000, op_add);
        send(32'h80000000, 32'h00000000, op_sub);
        send(32'h00000000, 32'hC0400000, op_add);
        send(32'h00000000, 32'h3F800000, op_sub);
        send(32'h3F800000, 32'h80000000, op_sub);
        send(32'h80000000, 32'h00000001, op_sub);
    endtask

    task automatic range_limits();
        send(32'h7F7FFFFF, 32'h7F7FFFFF, op_add);
        send(32'hFF7FFFFF, 32'h7F7FFFFF, op_sub);
        send(32'h7F000000, 32'h7F000000, op_add);
        send(32'h00800001, 32'h00800000, op_sub);
        send(32'h00C00000, 32'h00800000, op_sub);
        send(32'h3F800000, 32'h3F800000, op_sub);
        send(32'hBF800000, 32'h3F800000, op_add);
        send(32'hC0490FDB, 32'hC0490FDB, op_sub);
    endtask

    task automatic subnormal_operands();
        logic [31:0] a;
        logic [31:0] b;
        send(32'h00000001, 32'h00000001, op_add);
        send(32'h007FFFFF, 32'h00000001, op_add);
        send(32'h80400000, 32'h80400000, op_add);
        send(32'h00400000, 32'h3F800000, op_add);
        send(32'h3F800000, 32'h32000000, op_add);
        send(32'h3F800000, 32'h32000000, op_sub);
        send(32'h00800000, 32'h00000001, op_sub);
        repeat (30) begin
            next_rand(a);
            next_rand(b);
            // b lands on biased exponent 0 or 1
            send({a[31], 8'h00, a[22:0]}, {b[31], 7'd0, b[23], b[22:0]},
                 a[24] ? op_sub : op_add);
        end
    endtask

    task automatic random_burst();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sel;
        for (int n = 0; n < NUM_VECTORS; n++) begin
            random_word(a);
            random_word(b);
            next_rand(sel);
            // near-equal pairs to force deep cancellation
            if (sel[2:0] == 3'd0) begin
                b = a ^ {29'd0, sel[5:3]};
            end
            send(a, b, sel[8] ? op_sub : op_add);
            if (sel[12:9] == 4'd0) begin
                idle_cycle();
            end
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        operand_a = 32'd0;
        operand_b = 32'd0;
        operation = op_add;
        rng       = 32'd18691;
        chk       = 1'b0;
        timed_out = 1'b0;
        errors    = 0;
        checked   = 0;
        mark_err  = 0;
        mark_cnt  = 0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        assert (out_valid === 1'b0)
            else begin
                $display("** Error: out_valid = %h, expected 0 after reset", out_valid);
                errors++;
            end
        normal_operands();
        close_test("normal");
        special_operands();
        close_test("special");
        range_limits();
        close_test("range");
        subnormal_operands();
        close_test("subnormal");
        random_burst();
        close_test("burst");
        $display("total: %0d results checked, %0d errors", checked, errors);
        if (errors == 0 && !timed_out) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/fp_addsub_top.sv */
`timescale 1ns/100ps
`default_nettype none

module fp_addsub_top
    import fp_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  logic [31:0] operand_a,
    input  logic [31:0] operand_b,
    input  fp_op_t      operation,
    output logic        out_valid,
    output logic [31:0] result,
    output logic        overflow,
    output logic        underflow
);

    logic        special;
    logic [31:0] special_result;

    fp_stage_if stage_bus ();

    // nan, infinity and zero handling, no arithmetic needed
    fp_special_case u_special_case (
        .operand_a      (operand_a),
        .operand_b      (operand_b),
        .operation      (operation),
        .special        (special),
        .special_result (special_result)
    );

    // stage 1
    fp_align u_align (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .operand_a      (operand_a),
        .operand_b      (operand_b),
        .operation      (operation),
        .special        (special),
        .special_result (special_result),
        .stage          (stage_bus)
    );

    // stage 2
    fp_add_norm u_add_norm (
        .clk       (clk),
        .rst_n     (rst_n),
        .stage     (stage_bus),
        .out_valid (out_valid),
        .result    (result),
        .overflow  (overflow),
        .underflow (underflow)
    );

    // fixed two-cycle latency through both stages
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid == $past(in_valid, 2))
        else $error("fp_addsub_top: out_valid does not follow in_valid by two cycles");

endmodule

`default_nettype wire

/* src/fp_add_norm.sv */
`timescale 1ns/100ps
`include "fp_macros.svh"
`default_nettype none

module fp_add_norm (
    input  logic          clk,
    input  logic          rst_n,
    fp_stage_if.norm_side stage,
    output logic          out_valid,
    output logic [31:0]   result,
    output logic          overflow,
    output logic          underflow
);

    localparam int LZC_W = $clog2(`FP_SIG_W + 1);

    logic [`FP_SIG_W:0]   sum;
    logic [LZC_W-1:0]     lzc;
    logic                 lz_found;
    logic [`FP_EXP_W-1:0] shift_lim;
    logic [LZC_W-1:0]     shift_amt;
    logic [`FP_SIG_W-1:0] norm;
    logic [`FP_EXP_W:0]   exp_norm;
    logic [`FP_MAN_W-1:0] frac;
    logic [31:0]          result_c;
    logic                 overflow_c;
    logic                 underflow_c;

    assign sum = stage.effective_sub ?
                 ({1'b0, stage.sig_big} - {1'b0, stage.sig_small}) :
                 ({1'b0, stage.sig_big} + {1'b0, stage.sig_small});

    // leading zeros of the low FP_SIG_W bits
    always_comb begin
        lzc      = LZC_W'(`FP_SIG_W);
        lz_found = 1'b0;
        for (int i = `FP_SIG_W - 1; i >= 0; i--) begin
            if (!lz_found && sum[i]) begin
                lzc      = LZC_W'(`FP_SIG_W - 1 - i);
                lz_found = 1'b1;
            end
        end
    end

    // left shift may not take the exponent below 1
    assign shift_lim = stage.exp_big - `FP_EXP_W'(1);
    assign shift_amt = (`FP_EXP_W'(lzc) <= shift_lim) ? lzc : shift_lim[LZC_W-1:0];

    always_comb begin
        if (sum[`FP_SIG_W]) begin
            // carry out, keep the sticky while shifting right
            norm     = {sum[`FP_SIG_W:2], sum[1] | sum[0]};
            exp_norm = {1'b0, stage.exp_big} + 1'b1;
        end else begin
            norm     = sum[`FP_SIG_W-1:0] << shift_amt;
            exp_norm = {1'b0, stage.exp_big} - (`FP_EXP_W + 1)'(shift_amt);
        end
    end

    // truncation drops guard, round and sticky
    assign frac = norm[`FP_SIG_W-2 -: `FP_MAN_W];

    always_comb begin
        overflow_c  = 1'b0;
        underflow_c = 1'b0;
        if (stage.special) begin
            result_c = stage.special_result;
        end else if (norm == '0) begin
            // exact cancellation is +0
            result_c = 32'b0;
        end else if (exp_norm > (`FP_EXP_W + 1)'(`FP_EXP_MAX)) begin
            result_c   = {stage.sign_big, {`FP_EXP_W{1'b1}}, {`FP_MAN_W{1'b0}}};
            overflow_c = 1'b1;
        end else if (!norm[`FP_SIG_W-1]) begin
            // no hidden bit left, encode as subnormal
            result_c    = {stage.sign_big, {`FP_EXP_W{1'b0}}, frac};
            underflow_c = 1'b1;
        end else begin
            result_c = {stage.sign_big, exp_norm[`FP_EXP_W-1:0], frac};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            overflow  <= 1'b0;
            underflow <= 1'b0;
        end else begin
            out_valid <= stage.valid;
            overflow  <= stage.valid & overflow_c;
            underflow <= stage.valid & underflow_c;
        end
    end

    always_ff @(posedge clk) begin
        result <= result_c;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        !(overflow && underflow))
        else $error("fp_add_norm: overflow and underflow both set");

    // special results from stage 1 leave with clean flags
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && $past(stage.special) |-> !overflow && !underflow)
        else $error("fp_add_norm: flag raised on a special-case result");

endmodule

`default_nettype wire

/* src/fp_align.sv */
`timescale 1ns/100ps
`include "fp_macros.svh"
`default_nettype none

module fp_align
    import fp_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           in_valid,
    input  logic [31:0]    operand_a,
    input  logic [31:0]    operand_b,
    input  fp_op_t         operation,
    input  logic           special,
    input  logic [31:0]    special_result,
    fp_stage_if.align_side stage
);

    localparam int SHIFT_W = $clog2(`FP_SIG_W);

    logic                 sign_a;
    logic                 sign_b;
    logic [`FP_EXP_W-1:0] exp_a;
    logic [`FP_EXP_W-1:0] exp_b;
    logic [`FP_MAN_W:0]   sig_a;
    logic [`FP_MAN_W:0]   sig_b;
    logic                 a_is_big;
    logic [`FP_EXP_W-1:0] exp_big_c;
    logic [`FP_EXP_W-1:0] exp_diff;
    logic [`FP_SIG_W-1:0] sig_big_c;
    logic [`FP_SIG_W-1:0] small_ext;
    logic [`FP_SIG_W-1:0] lost_mask;
    logic [`FP_SIG_W-1:0] small_shifted;

    assign sign_a = operand_a[31];
    assign sign_b = operand_b[31] ^ (operation == op_sub);

    // subnormals take exponent 1 and no hidden bit
    assign exp_a = (operand_a[`FP_MAN_W +: `FP_EXP_W] == '0) ?
                   `FP_EXP_W'(1) : operand_a[`FP_MAN_W +: `FP_EXP_W];
    assign exp_b = (operand_b[`FP_MAN_W +: `FP_EXP_W] == '0) ?
                   `FP_EXP_W'(1) : operand_b[`FP_MAN_W +: `FP_EXP_W];
    assign sig_a = {|operand_a[`FP_MAN_W +: `FP_EXP_W], operand_a[`FP_MAN_W-1:0]};
    assign sig_b = {|operand_b[`FP_MAN_W +: `FP_EXP_W], operand_b[`FP_MAN_W-1:0]};

    // raw exponent:fraction order is the magnitude order
    assign a_is_big  = operand_a[30:0] >= operand_b[30:0];
    assign exp_big_c = a_is_big ? exp_a : exp_b;
    assign exp_diff  = a_is_big ? (exp_a - exp_b) : (exp_b - exp_a);
    assign sig_big_c = a_is_big ? {sig_a, 3'b000} : {sig_b, 3'b000};
    assign small_ext = a_is_big ? {sig_b, 3'b000} : {sig_a, 3'b000};

    // right shift, bits falling off collapse into sticky
    always_comb begin
        lost_mask     = '0;
        small_shifted = '0;
        if (exp_diff > `FP_EXP_W'(`FP_SIG_W - 1)) begin
            small_shifted[0] = |small_ext;
        end else begin
            lost_mask     = ~({`FP_SIG_W{1'b1}} << exp_diff[SHIFT_W-1:0]);
            small_shifted = small_ext >> exp_diff[SHIFT_W-1:0];
            small_shifted[0] = small_shifted[0] | (|(small_ext & lost_mask));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage.valid <= 1'b0;
        end else begin
            stage.valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        stage.special        <= special;
        stage.special_result <= special_result;
        stage.sign_big       <= a_is_big ? sign_a : sign_b;
        stage.exp_big        <= exp_big_c;
        stage.sig_big        <= sig_big_c;
        stage.sig_small      <= small_shifted;
        stage.effective_sub  <= sign_a ^ sign_b;
    end

    // stage 2 subtracts without a borrow path, so ordering must hold
    assert property (@(posedge clk) disable iff (!rst_n)
        stage.valid |-> stage.sig_big >= stage.sig_small)
        else $error("fp_align: shifted small significand exceeds large one");

endmodule

`default_nettype wire

/* src/fp_special_case.sv */
`timescale 1ns/100ps
`include "fp_macros.svh"
`default_nettype none

module fp_special_case
    import fp_pkg::*;
(
    input  logic [31:0] operand_a,
    input  logic [31:0] operand_b,
    input  fp_op_t      operation,
    output logic        special,
    output logic [31:0] special_result
);

    fp_class_t cls_a;
    fp_class_t cls_b;
    logic      sign_a;
    logic      sign_b;

    function automatic fp_class_t classify(input logic [31:0] word);
        logic [`FP_EXP_W-1:0] exp_f;
        logic [`FP_MAN_W-1:0] man_f;
        exp_f = word[`FP_MAN_W +: `FP_EXP_W];
        man_f = word[`FP_MAN_W-1:0];
        if (&exp_f) begin
            return (man_f != '0) ? cls_nan : cls_inf;
        end
        return (exp_f == '0 && man_f == '0) ? cls_zero : cls_finite;
    endfunction

    assign cls_a  = classify(operand_a);
    assign cls_b  = classify(operand_b);
    assign sign_a = operand_a[31];
    // effective sign of b after the operation is applied
    assign sign_b = operand_b[31] ^ (operation == op_sub);

    // priority follows nan, inf-inf, inf, zero+zero, single zero
    always_comb begin
        special        = 1'b1;
        special_result = `FP_QNAN;
        if (cls_a == cls_nan || cls_b == cls_nan) begin
            special_result = `FP_QNAN;
        end else if (cls_a == cls_inf && cls_b == cls_inf) begin
            special_result = (sign_a != sign_b) ? `FP_QNAN :
                             {sign_a, {`FP_EXP_W{1'b1}}, {`FP_MAN_W{1'b0}}};
        end else if (cls_a == cls_inf) begin
            special_result = {sign_a, {`FP_EXP_W{1'b1}}, {`FP_MAN_W{1'b0}}};
        end else if (cls_b == cls_inf) begin
            special_result = {sign_b, {`FP_EXP_W{1'b1}}, {`FP_MAN_W{1'b0}}};
        end else if (cls_a == cls_zero && cls_b == cls_zero) begin
            // -0 only when both effective signs are negative
            special_result = {sign_a & sign_b, 31'b0};
        end else if (cls_a == cls_zero) begin
            special_result = {sign_b, operand_b[30:0]};
        end else if (cls_b == cls_zero) begin
            special_result = operand_a;
        end else begin
            special        = 1'b0;
            special_result = 32'b0;
        end
    end

endmodule

`default_nettype wire

/* src/fp_stage_if.sv */
`timescale 1ns/100ps
`include "fp_macros.svh"
`default_nettype none

interface fp_stage_if;

    logic                 valid;
    logic                 special;
    logic [31:0]          special_result;
    // fields of the larger-magnitude operand
    logic                 sign_big;
    logic [`FP_EXP_W-1:0] exp_big;
    logic [`FP_SIG_W-1:0] sig_big;
    // smaller operand already shifted to exp_big
    logic [`FP_SIG_W-1:0] sig_small;
    logic                 effective_sub;

    modport align_side (
        output valid, special, special_result, sign_big, exp_big,
               sig_big, sig_small, effective_sub
    );

    modport norm_side (
        input valid, special, special_result, sign_big, exp_big,
              sig_big, sig_small, effective_sub
    );

endinterface

`default_nettype wire

/* src/fp_pkg.sv */
`default_nettype none

package fp_pkg;

    // operation select
    // op_sub flips the sign of operand b before the add
    typedef enum logic [0:0] {
        op_add = 1'b0,
        op_sub = 1'b1
    } fp_op_t;

    // operand class
    // cls_finite covers normal and subnormal values alike
    typedef enum logic [1:0] {
        cls_zero   = 2'd0,
        cls_finite = 2'd1,
        cls_inf    = 2'd2,
        cls_nan    = 2'd3
    } fp_class_t;

endpackage

`default_nettype wire

/* src/fp_macros.svh */
`ifndef FP_MACROS_SVH
`define FP_MACROS_SVH
`default_nettype none

// binary32 field widths
`define FP_EXP_W 8
`define FP_MAN_W 23

// exponent bias and largest finite biased exponent
`define FP_EXP_BIAS 127
`define FP_EXP_MAX 254

// canonical quiet nan, every nan result uses this word
`define FP_QNAN 32'h7FFFFFFF

// hidden bit + fraction + guard, round and sticky
`define FP_SIG_W (`FP_MAN_W + 4)

`default_nettype wire
`endif
